// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sim.f --top-module tb_ipod -Mdir obj_dir -o sim_ipod

run: compile
	out="$$(./obj_dir/sim_ipod)"; echo "$$out"; echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir

// ==== sim.f ====
source/ipod_pkg.sv
source/player_ctrl.sv
source/sample_rate.sv
source/sample_unpack.sv
source/hex_display.sv
source/ipod_top.sv
test/ipod_checker.sv
test/tb_ipod.sv

// ==== source/hex_display.sv ====
`timescale 1ns/100ps

module hex_display (
  input  logic                                            CLK_50M,
  input  logic                                            rst,
  input  logic [ipod_pkg::DIVIDER_W-1:0]                  divider,
  output logic [ipod_pkg::HEX_DIGITS*ipod_pkg::SEG_W-1:0] hex
);

  localparam int NIBBLES_W = ipod_pkg::HEX_DIGITS * 4;

  logic [NIBBLES_W-1:0] digits;

  // Active-low segments, bit 0 is segment a
  function automatic logic [ipod_pkg::SEG_W-1:0] seg_decode(input logic [3:0] nibble);
    case (nibble)
      4'h0:    seg_decode = 7'h40;
      4'h1:    seg_decode = 7'h79;
      4'h2:    seg_decode = 7'h24;
      4'h3:    seg_decode = 7'h30;
      4'h4:    seg_decode = 7'h19;
      4'h5:    seg_decode = 7'h12;
      4'h6:    seg_decode = 7'h02;
      4'h7:    seg_decode = 7'h78;
      4'h8:    seg_decode = 7'h00;
      4'h9:    seg_decode = 7'h10;
      4'hA:    seg_decode = 7'h08;
      4'hB:    seg_decode = 7'h03;
      4'hC:    seg_decode = 7'h46;
      4'hD:    seg_decode = 7'h21;
      4'hE:    seg_decode = 7'h06;
      default: seg_decode = 7'h0E;
    endcase
  endfunction

  // ======================================================================
  // Digit register, zero-extended divider
  // ======================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
      digits <= {{(NIBBLES_W-ipod_pkg::DIVIDER_W){1'b0}}, ipod_pkg::DEFAULT_DIVIDER};
    else
      digits <= {{(NIBBLES_W-ipod_pkg::DIVIDER_W){1'b0}}, divider};
  end

  // Lowest digit at the lowest bits
  always_comb
  begin
    for (int i = 0; i < ipod_pkg::HEX_DIGITS; i++)
      hex[i*ipod_pkg::SEG_W +: ipod_pkg::SEG_W] = seg_decode(digits[i*4 +: 4]);
  end

endmodule

// ==== source/ipod_pkg.sv ====
package ipod_pkg;

  // ======================================================================
  // Flash and sample sizes
  // ======================================================================
  localparam int FLASH_ADDR_W = 23;
  localparam int FLASH_DATA_W = 32;
  localparam int SAMPLE_W     = 8;

  // Last word of the song image
  localparam logic [FLASH_ADDR_W-1:0] LAST_ADDR = 23'h7FFFF;

  // ======================================================================
  // Playback rate
  // ======================================================================
  localparam int DIVIDER_W = 16;

  // 50 MHz / 2273 gives roughly 22 kHz
  localparam logic [DIVIDER_W-1:0] DEFAULT_DIVIDER = 16'd2273;
  localparam logic [DIVIDER_W-1:0] SPEED_STEP      = 16'd100;

  // Smallest divider is the fastest rate
  localparam logic [DIVIDER_W-1:0] MIN_DIVIDER = 16'd273;
  localparam logic [DIVIDER_W-1:0] MAX_DIVIDER = 16'd4273;

  // ======================================================================
  // Command bytes, uppercase ASCII only
  // ======================================================================
  localparam logic [7:0] CMD_START    = 8'h45;
  localparam logic [7:0] CMD_STOP     = 8'h44;
  localparam logic [7:0] CMD_FORWARD  = 8'h46;
  localparam logic [7:0] CMD_BACKWARD = 8'h42;
  localparam logic [7:0] CMD_RESTART  = 8'h52;

  // Seven-segment display
  localparam int HEX_DIGITS = 6;
  localparam int SEG_W      = 7;

  // Player controller states
  typedef enum logic [2:0] {
    idle,
    request,
    await_data,
    loaded,
    fetch_next
  } ctrl_state_t;

endpackage

// ==== source/ipod_top.sv ====
`timescale 1ns/100ps

module ipod_top (
  input  logic                                             CLK_50M,
  input  logic                                             rst,
  input  logic [7:0]                                       cmd_code,
  input  logic                                             cmd_strobe,
  input  logic                                             speed_up,
  input  logic                                             speed_down,
  input  logic                                             speed_reset,
  input  logic                                             flash_waitrequest,
  input  logic [ipod_pkg::FLASH_DATA_W-1:0]                flash_readdata,
  input  logic                                             flash_readdatavalid,
  output logic                                             flash_read,
  output logic [ipod_pkg::FLASH_ADDR_W-1:0]                flash_address,
  output logic [ipod_pkg::SAMPLE_W-1:0]                    sample,
  output logic                                             sample_strobe,
  output logic                                             playing,
  output logic [ipod_pkg::HEX_DIGITS*ipod_pkg::SEG_W-1:0]  hex
);

  logic                              word_strobe;
  logic [ipod_pkg::FLASH_DATA_W-1:0] word_data;
  logic                              word_done;
  logic                              direction;
  logic                              tick;
  logic [ipod_pkg::DIVIDER_W-1:0]    divider;

  // Commands, address sequencing and flash reads
  player_ctrl u_player_ctrl (
    .CLK_50M             (CLK_50M),
    .rst                 (rst),
    .cmd_code            (cmd_code),
    .cmd_strobe          (cmd_strobe),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .word_done           (word_done),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .word_strobe         (word_strobe),
    .word_data           (word_data),
    .direction           (direction),
    .playing             (playing)
  );

  sample_rate u_sample_rate (
    .CLK_50M     (CLK_50M),
    .rst         (rst),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .tick        (tick),
    .divider     (divider)
  );

  sample_unpack u_sample_unpack (
    .CLK_50M       (CLK_50M),
    .rst           (rst),
    .word_strobe   (word_strobe),
    .word_data     (word_data),
    .tick          (tick),
    .playing       (playing),
    .direction     (direction),
    .sample        (sample),
    .sample_strobe (sample_strobe),
    .word_done     (word_done)
  );

  hex_display u_hex_display (
    .CLK_50M (CLK_50M),
    .rst     (rst),
    .divider (divider),
    .hex     (hex)
  );

endmodule

// ==== source/player_ctrl.sv ====
`timescale 1ns/100ps

module player_ctrl (
  input  logic                              CLK_50M,
  input  logic                              rst,
  input  logic [7:0]                        cmd_code,
  input  logic                              cmd_strobe,
  input  logic                              flash_waitrequest,
  input  logic [ipod_pkg::FLASH_DATA_W-1:0] flash_readdata,
  input  logic                              flash_readdatavalid,
  input  logic                              word_done,
  output logic                              flash_read,
  output logic [ipod_pkg::FLASH_ADDR_W-1:0] flash_address,
  output logic                              word_strobe,
  output logic [ipod_pkg::FLASH_DATA_W-1:0] word_data,
  output logic                              direction,
  output logic                              playing
);

  ipod_pkg::ctrl_state_t             state;
  logic                              restart_cmd;
  logic                              restart_pend;
  logic [ipod_pkg::FLASH_ADDR_W-1:0] restart_addr;
  logic [ipod_pkg::FLASH_ADDR_W-1:0] step_addr;

  // ======================================================================
  // Command decoding
  // ======================================================================
  assign restart_cmd = cmd_strobe && (cmd_code == ipod_pkg::CMD_RESTART);

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      playing   <= 1'b0;
      direction <= 1'b0;
    end
    else if (cmd_strobe)
    begin
      case (cmd_code)
        ipod_pkg::CMD_START:    playing   <= 1'b1;
        ipod_pkg::CMD_STOP:     playing   <= 1'b0;
        ipod_pkg::CMD_FORWARD:  direction <= 1'b0;
        ipod_pkg::CMD_BACKWARD: direction <= 1'b1;
        default:                ;
      endcase
    end
  end

  // ======================================================================
  // Address sequencing
  // ======================================================================
  assign restart_addr = direction ? ipod_pkg::LAST_ADDR : '0;

  // Wrap at both ends of the song
  always_comb
  begin
    if (direction)
      step_addr = (flash_address == '0) ? ipod_pkg::LAST_ADDR : flash_address - 1'b1;
    else
      step_addr = (flash_address == ipod_pkg::LAST_ADDR) ? '0 : flash_address + 1'b1;
  end

  assign flash_read = (state == ipod_pkg::request);

  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      state         <= ipod_pkg::idle;
      flash_address <= '0;
      restart_pend  <= 1'b0;
      word_strobe   <= 1'b0;
    end
    else
    begin
      word_strobe <= 1'b0;
      // Restart during a word waits for that word to finish
      if (restart_cmd && state != ipod_pkg::idle)
        restart_pend <= 1'b1;
      case (state)
        ipod_pkg::idle:
        begin
          if (restart_cmd)
          begin
            flash_address <= restart_addr;
            state         <= ipod_pkg::request;
          end
          else if (playing)
            state <= ipod_pkg::request;
        end
        ipod_pkg::request:
          if (!flash_waitrequest)
            state <= ipod_pkg::await_data;
        ipod_pkg::await_data:
        begin
          if (flash_readdatavalid)
          begin
            word_strobe <= 1'b1;
            state       <= ipod_pkg::loaded;
          end
        end
        ipod_pkg::loaded:
          if (word_done)
            state <= ipod_pkg::fetch_next;
        ipod_pkg::fetch_next:
        begin
          flash_address <= (restart_pend || restart_cmd) ? restart_addr : step_addr;
          restart_pend  <= 1'b0;
          state         <= ipod_pkg::request;
        end
        default: state <= ipod_pkg::idle;
      endcase
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (state == ipod_pkg::await_data && flash_readdatavalid)
      word_data <= flash_readdata;
  end

  // Request must hold until the flash accepts it
  assert property (@(posedge CLK_50M) disable iff (rst)
    flash_read && flash_waitrequest |=> flash_read && $stable(flash_address));

  assert property (@(posedge CLK_50M) disable iff (rst)
    flash_address <= ipod_pkg::LAST_ADDR);

endmodule

// ==== source/sample_rate.sv ====
`timescale 1ns/100ps

module sample_rate (
  input  logic                           CLK_50M,
  input  logic                           rst,
  input  logic                           speed_up,
  input  logic                           speed_down,
  input  logic                           speed_reset,
  output logic                           tick,
  output logic [ipod_pkg::DIVIDER_W-1:0] divider
);

  // Button bits: 0 up, 1 down, 2 reset
  logic [2:0]                     btn_meta;
  logic [2:0]                     btn_sync;
  logic [2:0]                     btn_prev;
  logic [2:0]                     btn_rise;
  logic [ipod_pkg::DIVIDER_W-1:0] count;

  // ======================================================================
  // Synchronizer and rising-edge detect
  // ======================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      btn_meta <= '0;
      btn_sync <= '0;
      btn_prev <= '0;
    end
    else
    begin
      btn_meta <= {speed_reset, speed_down, speed_up};
      btn_sync <= btn_meta;
      btn_prev <= btn_sync;
    end
  end

  assign btn_rise = btn_sync & ~btn_prev;

  // Reset wins over up, up wins over down
  always_ff @(posedge CLK_50M)
  begin
    if (rst || btn_rise[2])
      divider <= ipod_pkg::DEFAULT_DIVIDER;
    else if (btn_rise[0])
      divider <= (divider < ipod_pkg::MIN_DIVIDER + ipod_pkg::SPEED_STEP) ?
                 ipod_pkg::MIN_DIVIDER : divider - ipod_pkg::SPEED_STEP;
    else if (btn_rise[1])
      divider <= (divider > ipod_pkg::MAX_DIVIDER - ipod_pkg::SPEED_STEP) ?
                 ipod_pkg::MAX_DIVIDER : divider + ipod_pkg::SPEED_STEP;
  end

  // ======================================================================
  // Sample tick, one pulse per divider cycles
  // ======================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      count <= ipod_pkg::DEFAULT_DIVIDER - 1'b1;
      tick  <= 1'b0;
    end
    else if (count == '0)
    begin
      count <= divider - 1'b1;
      tick  <= 1'b1;
    end
    else
    begin
      count <= count - 1'b1;
      tick  <= 1'b0;
    end
  end

  assert property (@(posedge CLK_50M) disable iff (rst)
    divider >= ipod_pkg::MIN_DIVIDER && divider <= ipod_pkg::MAX_DIVIDER);

endmodule

// ==== source/sample_unpack.sv ====
`timescale 1ns/100ps

module sample_unpack (
  input  logic                              CLK_50M,
  input  logic                              rst,
  input  logic                              word_strobe,
  input  logic [ipod_pkg::FLASH_DATA_W-1:0] word_data,
  input  logic                              tick,
  input  logic                              playing,
  input  logic                              direction,
  output logic [ipod_pkg::SAMPLE_W-1:0]     sample,
  output logic                              sample_strobe,
  output logic                              word_done
);

  // Only the upper byte of each half carries audio
  logic [ipod_pkg::SAMPLE_W-1:0] byte_hi;
  logic [ipod_pkg::SAMPLE_W-1:0] byte_lo;
  logic                          loaded;
  logic                          second_half;
  logic                          word_dir;

  always_ff @(posedge CLK_50M)
  begin
    if (word_strobe)
    begin
      byte_hi <= word_data[31:24];
      byte_lo <= word_data[15:8];
    end
  end

  // ======================================================================
  // Half sequencing
  // ======================================================================
  always_ff @(posedge CLK_50M)
  begin
    if (rst)
    begin
      loaded        <= 1'b0;
      second_half   <= 1'b0;
      word_dir      <= 1'b0;
      sample_strobe <= 1'b0;
      word_done     <= 1'b0;
    end
    else
    begin
      sample_strobe <= 1'b0;
      word_done     <= 1'b0;
      if (word_strobe)
      begin
        loaded      <= 1'b1;
        second_half <= 1'b0;
        // Direction is fixed per word
        word_dir    <= direction;
      end
      else if (tick && playing && loaded)
      begin
        sample_strobe <= 1'b1;
        if (second_half)
        begin
          loaded    <= 1'b0;
          word_done <= 1'b1;
        end
        else
          second_half <= 1'b1;
      end
    end
  end

  // Forward takes low half first, backward takes high half first
  always_ff @(posedge CLK_50M)
  begin
    if (tick && playing && loaded && !word_strobe)
      sample <= (second_half ^ word_dir) ? byte_hi : byte_lo;
  end

  // Controller only fetches after word_done
  assert property (@(posedge CLK_50M) disable iff (rst)
    word_strobe |-> !loaded);

endmodule

// ==== test/ipod_checker.sv ====
`timescale 1ns/100ps

module ipod_checker (
  input  logic                                            CLK_50M,
  input  logic                                            rst,
  input  logic [7:0]                                      cmd_code,
  input  logic                                            cmd_strobe,
  input  logic                                            speed_up,
  input  logic                                            speed_down,
  input  logic                                            speed_reset,
  input  logic                                            flash_read,
  input  logic [ipod_pkg::SAMPLE_W-1:0]                   sample,
  input  logic                                            sample_strobe,
  input  logic                                            playing,
  input  logic [ipod_pkg::HEX_DIGITS*ipod_pkg::SEG_W-1:0] hex,
  input  int                                              entries_done,
  output int                                              pass_count,
  output int                                              fail_count,
  output int                                              error_count
);

  localparam logic [31:0] SEED = 32'h4e25e021;
  localparam logic [22:0] LAST = 23'h7FFFF;

  int          cycle = 0;
  int          entry_errors = 0;
  int          last_entries = 0;
  int          hex_check_at = 3;
  int          last_change = 0;
  int          last_strobe = -1;
  logic        model_playing, model_dir, word_dir, started, word_seen, restart_pend, half;
  logic        up_q, down_q, reset_q;
  logic [22:0] addr;
  logic [15:0] model_div;
  logic [31:0] word;

  initial
  begin
    pass_count  = 0;
    fail_count  = 0;
    error_count = 0;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Active-low segments, gfedcba
  function automatic logic [6:0] seg_pattern(input logic [3:0] n);
    logic [6:0] table_seg [16];
    table_seg = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
                  7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};
    return table_seg[n];
  endfunction

  function automatic logic [41:0] expected_hex(input logic [15:0] div);
    logic [23:0] value;
    logic [41:0] result;
    value = {8'h00, div};
    for (int i = 0; i < 6; i++)
      result[i*7 +: 7] = seg_pattern(value[i*4 +: 4]);
    return result;
  endfunction

  task automatic note_error(input string text);
    $display("%s", text);
    error_count++;
    entry_errors++;
  endtask

  // ====================================================================
  // Output checks first, then the model follows this cycle's inputs
  // ====================================================================
  always @(posedge CLK_50M)
  begin : watch
    logic [7:0] exp_sample;
    if (rst)
    begin
      model_playing = 1'b0;
      model_dir     = 1'b0;
      started       = 1'b0;
      word_seen     = 1'b0;
      restart_pend  = 1'b0;
      half          = 1'b0;
      addr          = '0;
      model_div     = 16'd2273;
      up_q          = 1'b0;
      down_q        = 1'b0;
      reset_q       = 1'b0;
    end
    else
    begin
      if (flash_read && !started)
        note_error("Flash read issued before playback was started");
      // Status LED follows the last start or stop byte
      if (playing !== model_playing)
        note_error($sformatf("MISMATCH playing: expected 0x%h got 0x%h",
                             model_playing, playing));
      if (sample_strobe)
      begin
        if (!model_playing)
          note_error("Sample strobe seen while playback is stopped");
        if (!half)
        begin
          // New word, its address depends on restart and direction
          if (restart_pend)
            addr = model_dir ? LAST : 23'h0;
          else if (word_seen)
            addr = model_dir ? ((addr == 23'h0) ? LAST : addr - 23'h1)
                             : ((addr == LAST) ? 23'h0 : addr + 23'h1);
          word_seen    = 1'b1;
          restart_pend = 1'b0;
          word_dir     = model_dir;
          word         = xorshift({9'd0, addr} ^ SEED);
          exp_sample   = word_dir ? word[31:24] : word[15:8];
          half         = 1'b1;
        end
        else
        begin
          exp_sample = word_dir ? word[15:8] : word[31:24];
          half       = 1'b0;
        end
        if (sample !== exp_sample)
          note_error($sformatf("MISMATCH sample: addr 0x%06h expected 0x%02h got 0x%02h",
                               addr, exp_sample, sample));
        if (last_strobe >= 0 && last_strobe > last_change + 8 &&
            cycle - last_strobe != int'(model_div))
          note_error($sformatf("MISMATCH sample_strobe interval: expected 0x%04h got 0x%04h",
                               model_div, cycle - last_strobe));
        last_strobe = cycle;
      end
      if (cycle == hex_check_at && hex !== expected_hex(model_div))
        note_error($sformatf("MISMATCH hex: expected 0x%011h got 0x%011h",
                             expected_hex(model_div), hex));

      if (cmd_strobe)
      begin
        case (cmd_code)
          8'h45:
          begin
            model_playing = 1'b1;
            started       = 1'b1;
            last_strobe   = -1;
          end
          8'h44: model_playing = 1'b0;
          8'h46: model_dir = 1'b0;
          8'h42: model_dir = 1'b1;
          8'h52:
          begin
            restart_pend = 1'b1;
            started      = 1'b1;
          end
          default: ;
        endcase
      end

      // Rate buttons act on their rising edges
      if ((speed_up && !up_q) || (speed_down && !down_q) || (speed_reset && !reset_q))
      begin
        if (speed_reset)
          model_div = 16'd2273;
        else if (speed_up)
          model_div = (model_div < 16'd373) ? 16'd273 : model_div - 16'd100;
        else
          model_div = (model_div > 16'd4173) ? 16'd4273 : model_div + 16'd100;
        last_change  = cycle;
        hex_check_at = cycle + 5;
      end
      up_q    = speed_up;
      down_q  = speed_down;
      reset_q = speed_reset;
    end

    if (entries_done != last_entries)
    begin
      if (entry_errors == 0)
      begin
        pass_count++;
        $display("Entry %0d passed", last_entries);
      end
      else
      begin
        fail_count++;
        $display("Entry %0d failed with %0d errors", last_entries, entry_errors);
      end
      entry_errors = 0;
      last_entries = entries_done;
    end
    cycle++;
  end

endmodule

// ==== test/tb_ipod.sv ====
`timescale 1ns/100ps

module tb_ipod;

  localparam logic [31:0] SEED = 32'h4e25e021;
  localparam int NUM_STEPS = 20;
  localparam logic [2:0] ACT_NONE  = 3'd0;
  localparam logic [2:0] ACT_CMD   = 3'd1;
  localparam logic [2:0] ACT_UP    = 3'd2;
  localparam logic [2:0] ACT_DOWN  = 3'd3;
  localparam logic [2:0] ACT_RESET = 3'd4;

  typedef struct packed {
    logic [2:0]  kind;
    logic [7:0]  code;
    logic [7:0]  reps;
    logic [15:0] samples;
    logic [15:0] cycles;
  } step_t;

  // Action, command byte, presses, samples to wait, idle cycles
  step_t steps [NUM_STEPS] = '{
    '{ACT_NONE,  8'h00, 8'd0,  16'd0, 16'd5000},
    '{ACT_CMD,   8'h45, 8'd0,  16'd8, 16'd0},
    '{ACT_CMD,   8'h44, 8'd0,  16'd0, 16'd7000},
    '{ACT_CMD,   8'h45, 8'd0,  16'd4, 16'd0},
    '{ACT_CMD,   8'h42, 8'd0,  16'd0, 16'd0},
    '{ACT_CMD,   8'h52, 8'd0,  16'd6, 16'd0},
    '{ACT_CMD,   8'h46, 8'd0,  16'd6, 16'd0},
    '{ACT_CMD,   8'h52, 8'd0,  16'd4, 16'd0},
    '{ACT_CMD,   8'h42, 8'd0,  16'd6, 16'd0},
    '{ACT_CMD,   8'h46, 8'd0,  16'd2, 16'd0},
    '{ACT_UP,    8'h00, 8'd2,  16'd4, 16'd0},
    '{ACT_UP,    8'h00, 8'd40, 16'd2, 16'd0},
    '{ACT_RESET, 8'h00, 8'd1,  16'd3, 16'd0},
    '{ACT_DOWN,  8'h00, 8'd25, 16'd3, 16'd0},
    '{ACT_RESET, 8'h00, 8'd1,  16'd2, 16'd0},
    '{ACT_CMD,   8'h65, 8'd0,  16'd2, 16'd0},
    '{ACT_CMD,   8'h78, 8'd0,  16'd2, 16'd0},
    '{ACT_CMD,   8'h44, 8'd0,  16'd0, 16'd7000},
    '{ACT_CMD,   8'h65, 8'd0,  16'd0, 16'd7000},
    '{ACT_CMD,   8'h45, 8'd0,  16'd4, 16'd0}
  };

  logic        CLK_50M = 1'b0;
  logic        rst;
  logic [7:0]  cmd_code;
  logic        cmd_strobe, speed_up, speed_down, speed_reset;
  logic        flash_waitrequest, flash_readdatavalid;
  logic [31:0] flash_readdata;
  logic        flash_read, sample_strobe, playing;
  logic [22:0] flash_address;
  logic [7:0]  sample;
  logic [41:0] hex;
  logic [31:0] rng = SEED;
  int          entries_done = 0;
  int          pass_count, fail_count, error_count;

  always #10 CLK_50M = ~CLK_50M;

  ipod_top u_ipod_top (.*);

  ipod_checker u_checker (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic send_command(input logic [7:0] code);
    cmd_code   = code;
    cmd_strobe = 1'b1;
    @(negedge CLK_50M);
    cmd_strobe = 1'b0;
  endtask

  task automatic press_button(input logic [2:0] kind, input int count);
    repeat (count)
    begin
      speed_up    = (kind == ACT_UP);
      speed_down  = (kind == ACT_DOWN);
      speed_reset = (kind == ACT_RESET);
      repeat (4) @(negedge CLK_50M);
      speed_up    = 1'b0;
      speed_down  = 1'b0;
      speed_reset = 1'b0;
      repeat (4) @(negedge CLK_50M);
    end
  endtask

  task automatic wait_samples(input int count);
    int seen;
    seen = 0;
    while (seen < count)
    begin
      @(negedge CLK_50M);
      if (sample_strobe)
        seen++;
    end
  endtask

  // ====================================================================
  // Flash model with random wait and latency
  // ====================================================================
  initial
  begin : flash_responder
    logic [22:0] req_addr;
    forever
    begin
      @(negedge CLK_50M);
      if (flash_read)
      begin
        rng = xorshift(rng);
        repeat (int'(rng[1:0])) @(negedge CLK_50M);
        req_addr          = flash_address;
        flash_waitrequest = 1'b0;
        @(negedge CLK_50M);
        flash_waitrequest = 1'b1;
        rng = xorshift(rng);
        repeat (int'(rng[1:0])) @(negedge CLK_50M);
        flash_readdata      = xorshift({9'd0, req_addr} ^ SEED);
        flash_readdatavalid = 1'b1;
        @(negedge CLK_50M);
        flash_readdatavalid = 1'b0;
      end
    end
  end

  initial
  begin
    rst                 = 1'b1;
    cmd_code            = 8'h00;
    cmd_strobe          = 1'b0;
    speed_up            = 1'b0;
    speed_down          = 1'b0;
    speed_reset         = 1'b0;
    flash_waitrequest   = 1'b1;
    flash_readdata      = '0;
    flash_readdatavalid = 1'b0;
    repeat (3) @(negedge CLK_50M);
    rst = 1'b0;
    for (int i = 0; i < NUM_STEPS; i++)
    begin
      if (steps[i].kind == ACT_CMD)
        send_command(steps[i].code);
      else if (steps[i].kind != ACT_NONE)
        press_button(steps[i].kind, int'(steps[i].reps));
      wait_samples(int'(steps[i].samples));
      repeat (int'(steps[i].cycles)) @(negedge CLK_50M);
      entries_done = entries_done + 1;
    end
    repeat (3) @(negedge CLK_50M);
    $display("Entries passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0 && error_count == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

  // Limit follows the table length
  initial
  begin : watchdog
    int limit;
    limit = 100;
    for (int i = 0; i < NUM_STEPS; i++)
      limit += int'(steps[i].samples) * int'(ipod_pkg::MAX_DIVIDER) +
               int'(steps[i].cycles) + int'(steps[i].reps) * 8 + 200;
    repeat (limit) @(posedge CLK_50M);
    $display("Timeout: the stimulus table did not finish within %0d cycles", limit);
    $display("Result: FAILED");
    $finish;
  end

endmodule
